/* design/exu_cmd_queue.sv */
// One-entry command queue between the decoder and the execution stage
// The decoder must hold idu_cmd while idu_req is high and exu_rdy is low
// A flush drops the command taken at the same edge
`timescale 1ns/1ps
`default_nettype none

module exu_cmd_queue import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     idu_req,       // Decoder has a command
    input  exu_cmd_t idu_cmd,
    input  logic     barrier,       // Retirement side is halted
    input  logic     flush,         // PC redirect in this cycle
    output logic     exu_rdy,

    output logic     queue_vd,
    output exu_cmd_t queue_cmd
);

    logic load;

    // -------------------------------------------------------------------------
    // Handshake
    // -------------------------------------------------------------------------
    // Every command finishes in one cycle, only a halt stalls the decoder
    assign exu_rdy = ~barrier;
    assign load    = idu_req & exu_rdy;

    // -------------------------------------------------------------------------
    // Valid flag and payload
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            queue_vd <= 1'b0;
        end else if (barrier) begin
            queue_vd <= 1'b0;                   // Nothing enters while halted
        end else begin
            queue_vd <= idu_req & ~flush;       // Wrong-path command is dropped
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            queue_cmd <= idu_cmd;
        end
    end

    // -------------------------------------------------------------------------
    // Checks
    // -------------------------------------------------------------------------
    // Decoder side of the handshake, a stalled command must not change
    a_cmd_held : assert property (
        @(posedge clk) disable iff (!rst_n)
        (idu_req && !exu_rdy) |=> $stable(idu_cmd)
    ) else $error("exu_cmd_queue: idu_cmd changed while stalled");

endmodule

`default_nettype wire

/* design/exu_ialu.sv */
// Integer ALU of the execution stage, fully combinational
// Shifts use the low shamt_width bits of the second operand
// The target adder result is raw, alignment is done at retirement
`timescale 1ns/1ps
`default_nettype none

module exu_ialu import exu_pkg::*; (
    input  exu_cmd_t        queue_cmd,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] curr_pc,
    output ialu_res_t       ialu_res
);

    logic [xlen-1:0]        op2;
    logic [xlen:0]          diff;           // Top bit is the borrow
    logic [shamt_width-1:0] shamt;
    logic                   flag_eq;
    logic                   flag_lt;
    logic                   flag_ltu;
    logic [xlen-1:0]        alu_res;
    logic                   alu_cmp;
    logic [xlen-1:0]        sum2_base;
    logic [xlen-1:0]        sum2_res;

    // -------------------------------------------------------------------------
    // Operand select and flags
    // -------------------------------------------------------------------------
    assign op2   = (queue_cmd.ialu_op == ialu_op_reg_imm) ? queue_cmd.imm : rs2_data;
    assign shamt = op2[shamt_width-1:0];

    // One subtractor serves sub, slt and all branch compares
    assign diff     = {1'b0, rs1_data} - {1'b0, op2};
    assign flag_eq  = (rs1_data == op2);
    assign flag_ltu = diff[xlen];
    assign flag_lt  = (rs1_data[xlen-1] ^ op2[xlen-1]) ? rs1_data[xlen-1]
                                                       : diff[xlen-1];

    // -------------------------------------------------------------------------
    // Main result
    // -------------------------------------------------------------------------
    always_comb begin
        case (queue_cmd.ialu_cmd)
            ialu_cmd_add:  alu_res = rs1_data + op2;
            ialu_cmd_sub:  alu_res = diff[xlen-1:0];
            ialu_cmd_and:  alu_res = rs1_data & op2;
            ialu_cmd_or:   alu_res = rs1_data | op2;
            ialu_cmd_xor:  alu_res = rs1_data ^ op2;
            ialu_cmd_sll:  alu_res = rs1_data << shamt;
            ialu_cmd_srl:  alu_res = rs1_data >> shamt;
            ialu_cmd_sra:  alu_res = $signed(rs1_data) >>> shamt;  // Sign fill
            ialu_cmd_slt:  alu_res = {{(xlen-1){1'b0}}, flag_lt};
            ialu_cmd_sltu: alu_res = {{(xlen-1){1'b0}}, flag_ltu};
            default:       alu_res = '0;        // None and compares
        endcase
    end

    // -------------------------------------------------------------------------
    // Branch compare
    // -------------------------------------------------------------------------
    always_comb begin
        case (queue_cmd.ialu_cmd)
            ialu_cmd_eq:  alu_cmp = flag_eq;
            ialu_cmd_ne:  alu_cmp = ~flag_eq;
            ialu_cmd_lt:  alu_cmp = flag_lt;
            ialu_cmd_ge:  alu_cmp = ~flag_lt;
            ialu_cmd_ltu: alu_cmp = flag_ltu;
            ialu_cmd_geu: alu_cmp = ~flag_ltu;
            default:      alu_cmp = 1'b0;
        endcase
    end

    // -------------------------------------------------------------------------
    // Target adder
    // -------------------------------------------------------------------------
    // pc + imm for jal, branches and auipc; rs1 + imm for jalr
    assign sum2_base = (queue_cmd.sum2_op == sum2_op_reg_imm) ? rs1_data : curr_pc;
    assign sum2_res  = sum2_base + queue_cmd.imm;

    assign ialu_res = '{res: alu_res, sum2: sum2_res, cmp: alu_cmp};

endmodule

`default_nettype wire

/* design/exu_pkg.sv */
// Shared widths, encodings and bundles of the execution stage
// RV32I integer subset only; no loads, stores, CSRs or compressed forms
`default_nettype none

package exu_pkg;

    // -------------------------------------------------------------------------
    // Widths and vectors
    // -------------------------------------------------------------------------
    localparam int unsigned xlen          = 32;
    localparam int unsigned rf_addr_width = 5;
    localparam int unsigned shamt_width   = $clog2(xlen);    // Shift amount bits

    localparam logic [xlen-1:0] rst_vector  = 32'h0000_0200; // PC after reset exit
    localparam logic [xlen-1:0] trap_vector = 32'h0000_0100; // Common trap entry
    localparam logic [xlen-1:0] jump_mask   = 32'hffff_fffe; // Clears target bit 0

    // -------------------------------------------------------------------------
    // Encodings
    // -------------------------------------------------------------------------
    // Compares get their own codes, so five bits are needed
    typedef enum logic [4:0] {
        ialu_cmd_none,
        ialu_cmd_add,
        ialu_cmd_sub,
        ialu_cmd_and,
        ialu_cmd_or,
        ialu_cmd_xor,
        ialu_cmd_sll,
        ialu_cmd_srl,
        ialu_cmd_sra,
        ialu_cmd_slt,
        ialu_cmd_sltu,
        ialu_cmd_eq,        // Branch compares from here on
        ialu_cmd_ne,
        ialu_cmd_lt,
        ialu_cmd_ge,
        ialu_cmd_ltu,
        ialu_cmd_geu
    } ialu_cmd_e;

    typedef enum logic {ialu_op_reg_reg, ialu_op_reg_imm} ialu_op_e;
    typedef enum logic {sum2_op_pc_imm, sum2_op_reg_imm} sum2_op_e;   // Target adder base

    typedef enum logic [2:0] {
        rd_wb_none,
        rd_wb_ialu,
        rd_wb_sum2,
        rd_wb_imm,
        rd_wb_inc_pc        // Link address
    } rd_wb_sel_e;

    typedef enum logic [3:0] {
        exc_code_instr_misalign = 4'd0,
        exc_code_illegal_instr  = 4'd2,
        exc_code_breakpoint     = 4'd3,
        exc_code_ecall_m        = 4'd11
    } exc_code_e;

    // -------------------------------------------------------------------------
    // Bundles
    // -------------------------------------------------------------------------
    typedef struct packed {
        ialu_cmd_e                ialu_cmd;
        ialu_op_e                 ialu_op;
        sum2_op_e                 sum2_op;
        rd_wb_sel_e               rd_wb_sel;
        logic                     jump_req;
        logic                     branch_req;
        logic                     wfi_req;
        logic                     exc_req;    // Exception found by the decoder
        exc_code_e                exc_code;
        logic [rf_addr_width-1:0] rs1_addr;
        logic [rf_addr_width-1:0] rs2_addr;
        logic [rf_addr_width-1:0] rd_addr;
        logic [xlen-1:0]          imm;
    } exu_cmd_t;

    typedef struct packed {
        logic [xlen-1:0] res;
        logic [xlen-1:0] sum2;
        logic            cmp;
    } ialu_res_t;

    typedef struct packed {
        logic                     req;
        logic [rf_addr_width-1:0] addr;
        logic [xlen-1:0]          data;
    } rf_wr_t;

    typedef struct packed {
        logic            req;
        logic [xlen-1:0] pc;
    } pc_redirect_t;

    typedef struct packed {
        logic            req;
        exc_code_e       code;
        logic [xlen-1:0] val;
    } exc_info_t;

endpackage

`default_nettype wire

/* design/exu_retire.sv */
// Retirement side: exceptions, write-back, PC, reset exit and WFI
// Every valid command retires in its first cycle unless the stage is halted
// Exceptions redirect to trap_vector; there is no CSR state behind them
// A WFI retired while wake is high does not halt
`timescale 1ns/1ps
`default_nettype none

module exu_retire import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            queue_vd,
    input  exu_cmd_t        queue_cmd,
    input  ialu_res_t       ialu_res,
    input  logic            wake,           // Level, ends a WFI halt

    output logic            barrier,
    output pc_redirect_t    redirect,
    output rf_wr_t          rf_wr,
    output exc_info_t       exc,
    output logic [xlen-1:0] curr_pc,
    output logic            instret
);

    logic            retire;
    logic            jb_taken;
    logic [xlen-1:0] jb_target;
    logic            jb_misalign;
    logic            exc_req;
    logic [xlen-1:0] inc_pc;
    logic [2:0]      init_pc_v;
    logic            init_pc;
    logic            wfi_halt_cond;
    logic            wfi_halted;
    logic            wfi_run_start;

    // A command that slipped in as the halt began is dropped and refetched
    assign retire  = queue_vd & ~wfi_halted;
    assign instret = retire;
    assign barrier = wfi_halted;
    assign inc_pc  = curr_pc + xlen'(4);

    // -------------------------------------------------------------------------
    // Jumps, branches and exceptions
    // -------------------------------------------------------------------------
    assign jb_taken    = retire & (queue_cmd.jump_req | (queue_cmd.branch_req & ialu_res.cmp));
    assign jb_target   = ialu_res.sum2 & jump_mask;
    assign jb_misalign = jb_taken & jb_target[1];
    assign exc_req     = retire & (queue_cmd.exc_req | jb_misalign);

    always_comb begin
        exc.req = exc_req;
        if (queue_cmd.exc_req) begin
            exc.code = queue_cmd.exc_code;          // Decoded cause wins
            exc.val  = '0;
        end else begin
            exc.code = exc_code_instr_misalign;
            exc.val  = jb_misalign ? jb_target : '0;
        end
    end

    // -------------------------------------------------------------------------
    // Write-back
    // -------------------------------------------------------------------------
    always_comb begin
        rf_wr.req  = retire & ~exc_req
                   & (queue_cmd.rd_wb_sel != rd_wb_none)
                   & (queue_cmd.rd_addr != '0);         // x0 stays zero
        rf_wr.addr = queue_cmd.rd_addr;
        case (queue_cmd.rd_wb_sel)
            rd_wb_sum2:   rf_wr.data = ialu_res.sum2;   // auipc
            rd_wb_imm:    rf_wr.data = queue_cmd.imm;   // lui
            rd_wb_inc_pc: rf_wr.data = inc_pc;
            default:      rf_wr.data = ialu_res.res;
        endcase
    end

    // -------------------------------------------------------------------------
    // PC and redirect
    // -------------------------------------------------------------------------
    always_comb begin
        redirect.req = init_pc | exc_req | wfi_run_start | jb_taken;
        if (init_pc) begin
            redirect.pc = rst_vector;
        end else if (exc_req) begin
            redirect.pc = trap_vector;
        end else if (wfi_run_start) begin
            redirect.pc = curr_pc;              // Resume after the WFI
        end else begin
            redirect.pc = jb_target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= rst_vector;
        end else if (redirect.req) begin
            curr_pc <= redirect.pc;
        end else if (retire) begin
            curr_pc <= inc_pc;
        end
    end

    // Shift counter, init_pc is high in the third cycle out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_pc_v <= '0;
        end else if (!init_pc_v[2]) begin
            init_pc_v <= {init_pc_v[1:0], 1'b1};
        end
    end

    assign init_pc = init_pc_v[1] & ~init_pc_v[2];

    // -------------------------------------------------------------------------
    // WFI
    // -------------------------------------------------------------------------
    assign wfi_halt_cond = retire & queue_cmd.wfi_req & ~exc_req & ~wake;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wfi_halted    <= 1'b0;
            wfi_run_start <= 1'b0;
        end else begin
            wfi_run_start <= wfi_halted & wake;     // Exit redirect next cycle
            if (wfi_halt_cond) begin
                wfi_halted <= 1'b1;
            end else if (wake) begin
                wfi_halted <= 1'b0;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Checks
    // -------------------------------------------------------------------------
    a_jump_branch_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        queue_vd |-> !(queue_cmd.jump_req && queue_cmd.branch_req)
    ) else $error("exu_retire: jump and branch in one command");

    // The command taken along with a redirect is wrong-path and must not retire
    a_redirect_flush : assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect.req |=> !queue_vd
    ) else $error("exu_retire: command kept after redirect");

endmodule

`default_nettype wire

/* design/exu_top.sv */
// Execution stage of a small RV32I pipeline
// Register file reads are combinational and must return in the same cycle
// One command is in flight, rf_wr/redirect/exc are valid while instret is high
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    // Decoder
    input  logic                     idu_req,
    input  exu_cmd_t                 idu_cmd,
    output logic                     exu_rdy,

    // Register file
    output logic [rf_addr_width-1:0] rs1_addr,
    output logic [rf_addr_width-1:0] rs2_addr,
    input  logic [xlen-1:0]          rs1_data,
    input  logic [xlen-1:0]          rs2_data,
    output rf_wr_t                   rf_wr,

    // Control and status
    output pc_redirect_t             redirect,
    output exc_info_t                exc,
    output logic [xlen-1:0]          curr_pc,
    output logic                     instret,
    input  logic                     wake
);

    logic      queue_vd;
    exu_cmd_t  queue_cmd;
    ialu_res_t ialu_res;
    logic      barrier;

    assign rs1_addr = queue_cmd.rs1_addr;
    assign rs2_addr = queue_cmd.rs2_addr;

    exu_cmd_queue exu_cmd_queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .idu_req   (idu_req),
        .idu_cmd   (idu_cmd),
        .barrier   (barrier),
        .flush     (redirect.req),
        .exu_rdy   (exu_rdy),
        .queue_vd  (queue_vd),
        .queue_cmd (queue_cmd)
    );

    exu_ialu exu_ialu_i (
        .queue_cmd (queue_cmd),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .curr_pc   (curr_pc),
        .ialu_res  (ialu_res)
    );

    exu_retire exu_retire_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .queue_vd  (queue_vd),
        .queue_cmd (queue_cmd),
        .ialu_res  (ialu_res),
        .wake      (wake),
        .barrier   (barrier),
        .redirect  (redirect),
        .rf_wr     (rf_wr),
        .exc       (exc),
        .curr_pc   (curr_pc),
        .instret   (instret)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the execution stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_exu_top -o sim_exu

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/sim_exu > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    exit 1
fi
exit 0

/* tb.f */
design/exu_pkg.sv
design/exu_cmd_queue.sv
design/exu_ialu.sv
design/exu_retire.sv
design/exu_top.sv
test/tb_exu_checks.sv
test/tb_exu_top.sv

/* test/tb_exu_checks.sv */
// Reference model of retirement, checked on every falling clock edge
// Tracks the queued command, PC, reset exit and WFI state independently
`timescale 1ns/1ps
`default_nettype none

module tb_exu_checks import exu_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     idu_req,
    input  exu_cmd_t                 idu_cmd,
    input  logic                     exu_rdy,
    input  logic                     wake,
    input  logic [rf_addr_width-1:0] rs1_addr,
    input  logic [rf_addr_width-1:0] rs2_addr,
    input  rf_wr_t                   rf_wr,
    input  pc_redirect_t             redirect,
    input  exc_info_t                exc,
    input  logic [xlen-1:0]          curr_pc,
    input  logic                     instret,
    input  logic [xlen-1:0]          regs [32],
    output logic                     check_err
);

    exu_cmd_t        pend_cmd;
    logic            pending;
    logic            halted_m;
    logic            run_start_m;
    logic [xlen-1:0] exp_pc;
    int              rst_cycles;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            check_err = 1'b1;
        end
    endtask

    always @(negedge clk) begin : model
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] op2;
        logic [31:0] alu;
        logic        cmp;
        logic [31:0] sum2;
        logic [31:0] target;
        logic [31:0] wb;
        logic [31:0] pc_exp;
        logic        retire_exp;
        logic        taken;
        logic        misalign;
        logic        exc_exp;
        logic        wr_exp;
        logic        redir_exp;
        logic        init_exp;
        if (!rst_n) begin
            pending     = 1'b0;
            pend_cmd    = '0;
            halted_m    = 1'b0;
            run_start_m = 1'b0;
            exp_pc      = rst_vector;
            rst_cycles  = 0;
            check_err   = 1'b0;
        end else begin
            if (rst_cycles < 8) rst_cycles++;
            init_exp   = (rst_cycles == 3);        // Third cycle out of reset
            retire_exp = pending && !halted_m;
            r1  = regs[pend_cmd.rs1_addr];
            r2  = regs[pend_cmd.rs2_addr];
            op2 = (pend_cmd.ialu_op == ialu_op_reg_imm) ? pend_cmd.imm : r2;
            case (pend_cmd.ialu_cmd)
                ialu_cmd_add:  alu = r1 + op2;
                ialu_cmd_sub:  alu = r1 - op2;
                ialu_cmd_and:  alu = r1 & op2;
                ialu_cmd_or:   alu = r1 | op2;
                ialu_cmd_xor:  alu = r1 ^ op2;
                ialu_cmd_sll:  alu = r1 << op2[4:0];
                ialu_cmd_srl:  alu = r1 >> op2[4:0];
                ialu_cmd_sra:  alu = $signed(r1) >>> op2[4:0];
                ialu_cmd_slt:  alu = ($signed(r1) < $signed(op2)) ? 32'd1 : 32'd0;
                ialu_cmd_sltu: alu = (r1 < op2) ? 32'd1 : 32'd0;
                default:       alu = 32'd0;
            endcase
            case (pend_cmd.ialu_cmd)
                ialu_cmd_eq:  cmp = (r1 == op2);
                ialu_cmd_ne:  cmp = (r1 != op2);
                ialu_cmd_lt:  cmp = ($signed(r1) < $signed(op2));
                ialu_cmd_ge:  cmp = ($signed(r1) >= $signed(op2));
                ialu_cmd_ltu: cmp = (r1 < op2);
                ialu_cmd_geu: cmp = (r1 >= op2);
                default:      cmp = 1'b0;
            endcase
            sum2     = ((pend_cmd.sum2_op == sum2_op_reg_imm) ? r1 : exp_pc) + pend_cmd.imm;
            target   = {sum2[31:1], 1'b0};
            taken    = retire_exp && (pend_cmd.jump_req || (pend_cmd.branch_req && cmp));
            misalign = taken && target[1];
            exc_exp  = retire_exp && (pend_cmd.exc_req || misalign);
            case (pend_cmd.rd_wb_sel)
                rd_wb_sum2:   wb = sum2;
                rd_wb_imm:    wb = pend_cmd.imm;
                rd_wb_inc_pc: wb = exp_pc + 32'd4;
                default:      wb = alu;
            endcase
            wr_exp = retire_exp && !exc_exp && (pend_cmd.rd_wb_sel != rd_wb_none)
                     && (pend_cmd.rd_addr != 5'd0);
            redir_exp = init_exp || exc_exp || run_start_m || taken;
            if (init_exp) pc_exp = rst_vector;
            else if (exc_exp) pc_exp = trap_vector;
            else if (run_start_m) pc_exp = exp_pc;  // Resume after WFI
            else pc_exp = target;

            // ----------------------------------------------------------------------
            // Compare against the DUT
            // ----------------------------------------------------------------------
            compare("curr_pc", exp_pc, curr_pc);
            compare("exu_rdy", {31'd0, !halted_m}, {31'd0, exu_rdy});
            compare("instret", {31'd0, retire_exp}, {31'd0, instret});
            if (pending) begin
                compare("rs1_addr", {27'd0, pend_cmd.rs1_addr}, {27'd0, rs1_addr});
                compare("rs2_addr", {27'd0, pend_cmd.rs2_addr}, {27'd0, rs2_addr});
            end
            compare("redirect.req", {31'd0, redir_exp}, {31'd0, redirect.req});
            if (redir_exp) compare("redirect.pc", pc_exp, redirect.pc);
            compare("rf_wr.req", {31'd0, wr_exp}, {31'd0, rf_wr.req});
            if (wr_exp) begin
                compare("rf_wr.addr", {27'd0, pend_cmd.rd_addr}, {27'd0, rf_wr.addr});
                compare("rf_wr.data", wb, rf_wr.data);
            end
            compare("exc.req", {31'd0, exc_exp}, {31'd0, exc.req});
            if (exc_exp) begin
                compare("exc.code", {28'd0, pend_cmd.exc_req ? pend_cmd.exc_code
                                                             : exc_code_instr_misalign},
                        {28'd0, exc.code});
                compare("exc.val", pend_cmd.exc_req ? 32'd0 : target, exc.val);
            end

            // Next-state of the model
            if (redir_exp) exp_pc = pc_exp;
            else if (retire_exp) exp_pc = exp_pc + 32'd4;
            run_start_m = halted_m && wake;
            if (retire_exp && pend_cmd.wfi_req && !exc_exp && !wake) halted_m = 1'b1;
            else if (wake) halted_m = 1'b0;
            if (idu_req && exu_rdy) pend_cmd = idu_cmd;
            pending = idu_req && exu_rdy && !redir_exp;  // Flushed on redirect
        end
    end

endmodule

`default_nettype wire

/* test/tb_exu_top.sv */
// Testbench top: clock, reset, register file model and random commands
// Commands come from $urandom with a fixed seed; checks live in tb_exu_checks
`timescale 1ns/1ps
`default_nettype none

module tb_exu_top import exu_pkg::*;;

    logic                     clk;
    logic                     rst_n;
    logic                     idu_req;
    exu_cmd_t                 idu_cmd;
    logic                     exu_rdy;
    logic [rf_addr_width-1:0] rs1_addr;
    logic [rf_addr_width-1:0] rs2_addr;
    rf_wr_t                   rf_wr;
    pc_redirect_t             redirect;
    exc_info_t                exc;
    logic [xlen-1:0]          curr_pc;
    logic                     instret;
    logic                     wake;
    logic                     check_err;
    logic [xlen-1:0]          regs [32];

    exu_top exu_top_i (
        .clk(clk), .rst_n(rst_n), .idu_req(idu_req), .idu_cmd(idu_cmd), .exu_rdy(exu_rdy),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(regs[rs1_addr]), .rs2_data(regs[rs2_addr]),
        .rf_wr(rf_wr), .redirect(redirect), .exc(exc), .curr_pc(curr_pc),
        .instret(instret), .wake(wake)
    );

    tb_exu_checks checks_i (
        .clk(clk), .rst_n(rst_n), .idu_req(idu_req), .idu_cmd(idu_cmd), .exu_rdy(exu_rdy),
        .wake(wake), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rf_wr(rf_wr), .redirect(redirect), .exc(exc), .curr_pc(curr_pc),
        .instret(instret), .regs(regs), .check_err(check_err)
    );

    always #20 clk = ~clk;

    // Register file model, x0 hard-wired
    always @(posedge clk) begin
        if (rf_wr.req && rf_wr.addr != 5'd0) regs[rf_wr.addr] <= rf_wr.data;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    always @(posedge check_err) fail_run("reference model mismatch");

    task automatic wait_rdy(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (exu_rdy !== level) begin
            n++;
            if (n > 50) fail_run("timeout waiting for exu_rdy to change");
            @(negedge clk);
        end
    endtask

    task automatic send_cmd(input exu_cmd_t cmd);
        idu_req <= 1'b1;
        idu_cmd <= cmd;
        wait_rdy(1'b1);
        @(posedge clk);                         // Accepted at this edge
    endtask

    task automatic idle(input int cycles);
        idu_req <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    function automatic exu_cmd_t random_cmd();
        exu_cmd_t c;
        int       kind;
        c          = '0;
        kind       = $urandom_range(0, 9);
        c.rs1_addr = 5'($urandom_range(0, 7));
        c.rs2_addr = 5'($urandom_range(0, 7));
        c.rd_addr  = 5'($urandom_range(0, 7));
        c.imm      = $urandom;
        if (kind <= 3) begin
            c.ialu_cmd  = ialu_cmd_e'(5'($urandom_range(1, 10)));
            c.ialu_op   = ialu_op_e'(1'($urandom_range(0, 1)));
            c.rd_wb_sel = rd_wb_ialu;
        end else if (kind == 4) begin
            c.sum2_op   = sum2_op_e'(1'($urandom_range(0, 1)));
            c.rd_wb_sel = rd_wb_sel_e'(3'($urandom_range(2, 4)));
        end else if (kind == 5) begin
            c.jump_req  = 1'b1;
            c.sum2_op   = sum2_op_e'(1'($urandom_range(0, 1)));
            c.imm       = 32'($urandom_range(0, 255)) << 1;
            c.rd_wb_sel = rd_wb_inc_pc;
        end else if (kind <= 7) begin
            c.branch_req = 1'b1;
            c.ialu_cmd   = ialu_cmd_e'(5'($urandom_range(11, 16)));
            c.imm        = 32'($urandom_range(0, 255)) << 1;
        end else if (kind == 8) begin
            c.exc_req   = 1'b1;
            c.exc_code  = ($urandom_range(0, 1) == 0) ? exc_code_illegal_instr
                                                      : exc_code_ecall_m;
            c.rd_wb_sel = rd_wb_ialu;
            c.ialu_cmd  = ialu_cmd_add;
        end
        return c;
    endfunction

    task automatic run_wfi();
        exu_cmd_t c;
        c         = '0;
        c.wfi_req = 1'b1;
        idle(2);                                // No redirect at acceptance
        send_cmd(c);
        idu_req <= 1'b0;
        wait_rdy(1'b0);
        repeat ($urandom_range(1, 4)) @(posedge clk);
        wake <= 1'b1;
        wait_rdy(1'b1);
        @(posedge clk);
        wake <= 1'b0;
    endtask

    initial begin
        void'($urandom(94));
        rst_n   = 1'b0;
        clk     = 1'b0;
        idu_req = 1'b0;
        idu_cmd = '0;
        wake    = 1'b0;
        for (int i = 0; i < 32; i++) regs[i] = (i == 0) ? 32'd0 : $urandom;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (6) @(posedge clk);              // Past the reset-exit redirect
        for (int n = 0; n < 400; n++) begin
            if (n % 50 == 49) run_wfi();
            else if ($urandom_range(0, 4) == 0) idle(1);
            else send_cmd(random_cmd());
        end
        idle(4);
        if (check_err === 1'b1) begin
            fail_run("check failed at end of run");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
